//--- hdl/decode_config.svh
// Decode stage sizing: datapath width, register count and link register number
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

`define WORD_WIDTH 16  // Datapath and instruction width
`define REG_COUNT  8   // Architectural registers
`define LINK_REG   7   // Written by JAL and JALR

`endif

//--- hdl/isa_pkg.sv
// Instruction set package: word, register index and opcode types with field extraction
`default_nettype none

`include "decode_config.svh"

package isaPkg;

    typedef logic [`WORD_WIDTH-1:0]        word_t;    // Instruction, operand or immediate
    typedef logic [$clog2(`REG_COUNT)-1:0] regIdx_t;  // Register number
    typedef logic [4:0]                    opcode_t;  // Top five instruction bits

    localparam opcode_t opHalt = 5'b00000;
    localparam opcode_t opSiic = 5'b00010;
    localparam opcode_t opRti  = 5'b00011;
    localparam opcode_t opSlbi = 5'b10010;
    localparam opcode_t opStu  = 5'b10011;
    localparam opcode_t opLbi  = 5'b11000;

    function automatic opcode_t opField(word_t instr);
        return instr[`WORD_WIDTH-1 -: 5];
    endfunction

    function automatic regIdx_t rsField(word_t instr);
        return instr[10:8];  // Rs, also LBI/SLBI/STU target
    endfunction

    function automatic regIdx_t rtField(word_t instr);
        return instr[7:5];  // Rt in R-format, Rd in I-format 1
    endfunction

    function automatic regIdx_t rdField(word_t instr);
        return instr[4:2];  // Rd in R-format
    endfunction

endpackage

`default_nettype wire

//--- hdl/ctrl_pkg.sv
// Control field package: destination, immediate and link selects plus ALU operation codes
`default_nettype none

package ctrlPkg;

    typedef enum logic [1:0] {
        destRs   = 2'b00,  // Bits 10..8
        destRdR  = 2'b01,  // Bits 4..2
        destLink = 2'b10,  // Link register
        destRdI  = 2'b11   // Bits 7..5
    } destSel_t;

    typedef logic [2:0] immSel_t;  // {sign extend, field size}

    localparam logic [1:0] immSize5  = 2'b00;
    localparam logic [1:0] immSize8  = 2'b01;
    localparam logic [1:0] immSize11 = 2'b10;

    localparam immSel_t immZext5  = {1'b0, immSize5};
    localparam immSel_t immSext5  = {1'b1, immSize5};
    localparam immSel_t immZext8  = {1'b0, immSize8};
    localparam immSel_t immSext8  = {1'b1, immSize8};
    localparam immSel_t immSext11 = {1'b1, immSize11};

    typedef enum logic [1:0] {
        linkNone = 2'b00,
        linkLbi  = 2'b01,  // Load immediate into Rs
        linkJump = 2'b10   // Write PC + 2 to link register
    } linkSel_t;

    typedef logic [4:0] aluOp_t;  // Normally the opcode itself

    localparam aluOp_t aluNop  = 5'b00001;
    localparam aluOp_t aluAddi = 5'b01000;  // Jump group forms PC + 2

endpackage

`default_nettype wire

//--- hdl/instrLatch.sv
// Instruction latch: takes strobed instructions, holds on stall, drops on flush and after halt
`default_nettype none

module instrLatch (
    input  wire                clk,
    input  wire                reset,
    input  wire isaPkg::word_t instr,       // From fetch
    input  wire                instrValid,  // Strobe for instr
    input  wire                stall,
    input  wire                flush,
    input  wire                haltSeen,    // Valid halt leaving the stage
    output isaPkg::word_t      idInstr,
    output logic               idValid
);

    logic haltedLatch;  // Sticky, blocks capture until reset
    logic accept;       // New instruction taken this edge

    assign accept = instrValid && !stall && !haltedLatch && !haltSeen;

    always_ff @(posedge clk) begin
        if (reset) begin
            idValid     <= 1'b0;
            haltedLatch <= 1'b0;
        end else begin
            if (haltSeen)
                haltedLatch <= 1'b1;
            if (flush)
                idValid <= 1'b0;      // Flush beats stall
            else if (!stall)
                idValid <= accept;    // Old one moved on, refill or empty
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !flush)
            idInstr <= instr;         // Held while stalled
    end

endmodule

`default_nettype wire

//--- hdl/control.sv
// Control decoder: maps the 5-bit opcode to every control level of the pipeline
`default_nettype none

module control (
    input  wire isaPkg::opcode_t opcode,
    output logic                 regWrite,    // Register file write
    output ctrlPkg::destSel_t    destRegSel,  // Which field names the target
    output logic                 pcSel,       // PC + 2 + displacement
    output logic                 regJmp,      // Jump to Rs + imm
    output logic                 memEnable,   // Data memory access
    output logic                 memWr,       // Data memory write
    output ctrlPkg::aluOp_t      aluCntrl,
    output logic                 val2Reg,     // Memory data to register
    output logic                 aluSel,      // Immediate as second operand
    output ctrlPkg::immSel_t     immSel,
    output logic                 halt,
    output ctrlPkg::linkSel_t    linkReg,
    output logic                 siic,
    output logic                 bFlag
);

    always_comb begin
        regWrite   = 1'b0;               // Safe levels, no state change
        destRegSel = ctrlPkg::destRdI;
        pcSel      = 1'b0;
        regJmp     = 1'b0;
        memEnable  = 1'b0;
        memWr      = 1'b0;
        aluCntrl   = opcode;             // Opcode doubles as ALU op
        val2Reg    = 1'b0;               // ALU result to register
        aluSel     = 1'b1;
        immSel     = ctrlPkg::immSext5;
        halt       = 1'b0;
        linkReg    = ctrlPkg::linkNone;
        siic       = 1'b0;
        bFlag      = 1'b0;

        unique casez (opcode)
            5'b000??: begin              // HALT, NOP, SIIC, RTI
                bFlag = 1'b1;
                case (opcode)
                    isaPkg::opHalt: halt     = 1'b1;
                    isaPkg::opSiic: siic     = 1'b1;  // Passed on only
                    isaPkg::opRti:  aluCntrl = ctrlPkg::aluNop;
                endcase
            end

            5'b010??, 5'b101??: begin    // ADDI SUBI XORI ANDNI ROLI SLLI RORI SRLI
                regWrite = 1'b1;
                immSel   = opcode[1] ? ctrlPkg::immZext5
                                     : ctrlPkg::immSext5;  // Logic ops zero extend
            end

            5'b1000?: begin              // ST, LD
                memEnable = 1'b1;        // Address Rs + sext imm
                if (opcode[0]) begin     // LD
                    regWrite = 1'b1;
                    val2Reg  = 1'b1;
                end else begin           // ST
                    memWr = 1'b1;
                end
            end

            isaPkg::opStu: begin         // Store and write address back to Rs
                destRegSel = ctrlPkg::destRs;
                regWrite   = 1'b1;
                memEnable  = 1'b1;
                memWr      = 1'b1;
            end

            5'b11001, 5'b1101?, 5'b111??: begin  // BTR, ALU ops, shifts, compares
                destRegSel = ctrlPkg::destRdR;
                aluSel     = 1'b0;       // Rt as second operand
                immSel     = ctrlPkg::immZext5;
                regWrite   = 1'b1;
            end

            5'b011??: begin              // BEQZ BNEZ BLTZ BGEZ
                destRegSel = ctrlPkg::destRs;
                aluSel     = 1'b0;
                immSel     = ctrlPkg::immSext8;
                bFlag      = 1'b1;       // Resolved in execute
            end

            isaPkg::opLbi: begin
                destRegSel = ctrlPkg::destRs;
                regWrite   = 1'b1;
                immSel     = ctrlPkg::immSext8;
                linkReg    = ctrlPkg::linkLbi;
            end

            isaPkg::opSlbi: begin        // Rs <- (Rs << 8) | imm
                destRegSel = ctrlPkg::destRs;
                regWrite   = 1'b1;
                immSel     = ctrlPkg::immZext8;
            end

            5'b001??: begin              // J, JR, JAL, JALR
                destRegSel = ctrlPkg::destLink;
                aluCntrl   = ctrlPkg::aluAddi;
                bFlag      = 1'b1;
                if (opcode[0]) begin     // Register jumps
                    regJmp = 1'b1;
                    immSel = ctrlPkg::immSext8;
                end else begin           // Displacement jumps
                    pcSel  = 1'b1;
                    immSel = ctrlPkg::immSext11;
                end
                if (opcode[1]) begin     // Linking forms
                    regWrite = 1'b1;
                    linkReg  = ctrlPkg::linkJump;
                    bFlag    = ~opcode[0];  // JALR clears it
                end
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/immExtend.sv
// Immediate extender: picks the 5-, 8- or 11-bit field and sign or zero extends it
`default_nettype none

module immExtend (
    input  wire isaPkg::word_t    instr,
    input  wire ctrlPkg::immSel_t immSel,  // {sign extend, size}
    output isaPkg::word_t         imm
);

    localparam int wordBits = $bits(isaPkg::word_t);

    logic fill;  // Upper bits, zero unless sign extending

    always_comb begin
        case (immSel[1:0])
            ctrlPkg::immSize5: begin
                fill = immSel[2] & instr[4];
                imm  = {{(wordBits-5){fill}}, instr[4:0]};
            end
            ctrlPkg::immSize8: begin
                fill = immSel[2] & instr[7];
                imm  = {{(wordBits-8){fill}}, instr[7:0]};
            end
            ctrlPkg::immSize11: begin
                fill = immSel[2] & instr[10];
                imm  = {{(wordBits-11){fill}}, instr[10:0]};
            end
            default: begin       // Size code never issued
                fill = 1'b0;
                imm  = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/regFile.sv
// Register file: eight words, two combinational reads, one write with same-cycle bypass
`default_nettype none

`include "decode_config.svh"

module regFile (
    input  wire                  clk,
    input  wire                  reset,
    input  wire isaPkg::regIdx_t readReg1,
    input  wire isaPkg::regIdx_t readReg2,
    input  wire                  writeEnable,
    input  wire isaPkg::regIdx_t writeReg,
    input  wire isaPkg::word_t   writeData,
    output isaPkg::word_t        readData1,
    output isaPkg::word_t        readData2
);

    isaPkg::word_t regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++)
                regs[i] <= '0;
        end else if (writeEnable) begin
            regs[writeReg] <= writeData;
        end
    end

    // Write data wins over the array in the same cycle
    assign readData1 = (writeEnable && writeReg == readReg1) ? writeData : regs[readReg1];
    assign readData2 = (writeEnable && writeReg == readReg2) ? writeData : regs[readReg2];

endmodule

`default_nettype wire

//--- hdl/decodeOut.sv
// Decode/execute register: picks the destination index, inserts bubbles and tracks halt
`default_nettype none

`include "decode_config.svh"

module decodeOut (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     stall,
    input  wire                     idValid,
    input  wire isaPkg::word_t      idInstr,
    input  wire                     regWrite,
    input  wire ctrlPkg::destSel_t  destRegSel,
    input  wire                     pcSel,
    input  wire                     regJmp,
    input  wire                     memEnable,
    input  wire                     memWr,
    input  wire ctrlPkg::aluOp_t    aluCntrl,
    input  wire                     val2Reg,
    input  wire                     aluSel,
    input  wire                     halt,
    input  wire ctrlPkg::linkSel_t  linkReg,
    input  wire                     siic,
    input  wire                     bFlag,
    input  wire isaPkg::word_t      idImm,
    input  wire isaPkg::word_t      rsData,
    input  wire isaPkg::word_t      rtData,
    output logic                    exValid,
    output isaPkg::word_t           exRsData,
    output isaPkg::word_t           exRtData,
    output isaPkg::word_t           exImm,
    output isaPkg::regIdx_t         exDestReg,
    output ctrlPkg::aluOp_t         exAluOp,
    output logic                    exRegWrite,
    output logic                    exMemEnable,
    output logic                    exMemWr,
    output logic                    exVal2Reg,
    output logic                    exAluSel,
    output logic                    exPcSel,
    output logic                    exRegJmp,
    output logic                    exBFlag,
    output ctrlPkg::linkSel_t       exLinkSel,
    output logic                    exSiic,
    output logic                    haltSeen,  // One cycle, back to the latch
    output logic                    halted
);

    logic            load;     // Real instruction moves on this edge
    logic            exHalt;
    isaPkg::regIdx_t destReg;

    assign load     = idValid && !stall && !haltSeen && !halted;
    assign haltSeen = exValid && exHalt;

    always_comb begin
        case (destRegSel)
            ctrlPkg::destRs:   destReg = isaPkg::rsField(idInstr);
            ctrlPkg::destRdR:  destReg = isaPkg::rdField(idInstr);
            ctrlPkg::destLink: destReg = isaPkg::regIdx_t'(`LINK_REG);
            default:           destReg = isaPkg::rtField(idInstr);  // Rd of I-format
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            exValid     <= 1'b0;
            exRegWrite  <= 1'b0;
            exMemEnable <= 1'b0;
            exMemWr     <= 1'b0;
            exPcSel     <= 1'b0;
            exRegJmp    <= 1'b0;
            exBFlag     <= 1'b0;
            exLinkSel   <= ctrlPkg::linkNone;
            exSiic      <= 1'b0;
            exHalt      <= 1'b0;
            halted      <= 1'b0;
        end else begin
            exValid     <= load;               // Bubble when low
            exRegWrite  <= load && regWrite;
            exMemEnable <= load && memEnable;
            exMemWr     <= load && memWr;
            exPcSel     <= load && pcSel;
            exRegJmp    <= load && regJmp;
            exBFlag     <= load && bFlag;
            exLinkSel   <= load ? linkReg : ctrlPkg::linkNone;
            exSiic      <= load && siic;
            exHalt      <= load && halt;
            if (haltSeen)
                halted <= 1'b1;                // Sticky until reset
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            exRsData  <= rsData;
            exRtData  <= rtData;
            exImm     <= idImm;
            exDestReg <= destReg;
            exAluOp   <= aluCntrl;
            exVal2Reg <= val2Reg;
            exAluSel  <= aluSel;
        end
    end

endmodule

`default_nettype wire

//--- hdl/decodeStage.sv
// Decode stage top: latch, control decoder, immediate extender, register file, output register
`default_nettype none

module decodeStage (
    input  wire                     clk,
    input  wire                     reset,
    input  wire isaPkg::word_t      instr,
    input  wire                     instrValid,
    input  wire                     stall,
    input  wire                     flush,
    input  wire                     wbEnable,  // Write-back port
    input  wire isaPkg::regIdx_t    wbReg,
    input  wire isaPkg::word_t      wbData,
    output logic                    exValid,
    output isaPkg::word_t           exRsData,
    output isaPkg::word_t           exRtData,
    output isaPkg::word_t           exImm,
    output isaPkg::regIdx_t         exDestReg,
    output ctrlPkg::aluOp_t         exAluOp,
    output logic                    exRegWrite,
    output logic                    exMemEnable,
    output logic                    exMemWr,
    output logic                    exVal2Reg,
    output logic                    exAluSel,
    output logic                    exPcSel,
    output logic                    exRegJmp,
    output logic                    exBFlag,
    output ctrlPkg::linkSel_t       exLinkSel,
    output logic                    exSiic,
    output logic                    halted
);

    wire isaPkg::word_t     idInstr;   // Latched instruction
    wire                    idValid;
    wire                    haltSeen;
    wire                    regWrite;
    wire ctrlPkg::destSel_t destRegSel;
    wire                    pcSel;
    wire                    regJmp;
    wire                    memEnable;
    wire                    memWr;
    wire ctrlPkg::aluOp_t   aluCntrl;
    wire                    val2Reg;
    wire                    aluSel;
    wire ctrlPkg::immSel_t  immSel;
    wire                    halt;
    wire ctrlPkg::linkSel_t linkReg;
    wire                    siic;
    wire                    bFlag;
    wire isaPkg::word_t     idImm;
    wire isaPkg::word_t     rsData;
    wire isaPkg::word_t     rtData;

    instrLatch latch (.*);

    control ctrl (
        .opcode(isaPkg::opField(idInstr)),
        .*
    );

    immExtend immExt (
        .instr(idInstr),
        .imm  (idImm),
        .*
    );

    regFile regs (
        .clk        (clk),
        .reset      (reset),
        .readReg1   (isaPkg::rsField(idInstr)),
        .readReg2   (isaPkg::rtField(idInstr)),
        .writeEnable(wbEnable),
        .writeReg   (wbReg),
        .writeData  (wbData),
        .readData1  (rsData),
        .readData2  (rtData)
    );

    decodeOut outReg (.*);

endmodule

`default_nettype wire

//--- tb/decodeStage_chk.sv
// Decode stage assertions: memory write level, bubble write levels and sticky halt
`default_nettype none

module decodeStage_chk (
    input wire clk,
    input wire reset,
    input wire exValid,
    input wire exRegWrite,
    input wire exMemEnable,
    input wire exMemWr,
    input wire halted
);

    int failCount = 0;  // Assertion failures so far

    // A store always comes with a memory access
    memWrNeedsEnable: assert property (@(posedge clk) disable iff (reset)
        exMemWr |-> exMemEnable)
        else begin
            failCount++;
            $error("exMemWr high while exMemEnable low");
        end

    bubbleWritesLow: assert property (@(posedge clk) disable iff (reset)
        !exValid |-> (!exRegWrite && !exMemWr))  // Bubbles change no state
        else begin
            failCount++;
            $error("write level high in a bubble");
        end

    haltedSticky: assert property (@(posedge clk)
        $fell(halted) |-> $past(reset))      // Only reset clears it
        else begin
            failCount++;
            $error("halted fell without reset");
        end

endmodule

bind decodeStage decodeStage_chk chk (.*);

`default_nettype wire

//--- tb/decodeStage_tb.sv
// Decode stage testbench that replays the vector file on the DUT and checks the execute outputs
`default_nettype none

`include "decode_config.svh"

module decodeStage_tb;

    localparam int maxLines = 64;  // Vector limit for the replay loop

    logic              clk;
    logic              reset;
    isaPkg::word_t     instr;
    logic              instrValid;
    logic              stall;
    logic              flush;
    logic              wbEnable;
    isaPkg::regIdx_t   wbReg;
    isaPkg::word_t     wbData;
    logic              exValid;
    isaPkg::word_t     exRsData;
    isaPkg::word_t     exRtData;
    isaPkg::word_t     exImm;
    isaPkg::regIdx_t   exDestReg;
    ctrlPkg::aluOp_t   exAluOp;
    logic              exRegWrite;
    logic              exMemEnable;
    logic              exMemWr;
    logic              exVal2Reg;
    logic              exAluSel;
    logic              exPcSel;
    logic              exRegJmp;
    logic              exBFlag;
    ctrlPkg::linkSel_t exLinkSel;
    logic              exSiic;
    logic              halted;

    int checks     = 0;
    int errors     = 0;
    int lineErrors = 0;  // Mismatches in the current vector

    decodeStage dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic checkWord(input string name, input isaPkg::word_t expected,
                             input isaPkg::word_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            lineErrors++;
            $display("FAIL %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic checkReg(input string name, input isaPkg::regIdx_t expected,
                            input isaPkg::regIdx_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            lineErrors++;
            $display("FAIL %0t %s expected %0d actual %0d", $time, name, expected, actual);
        end
    endtask

    task automatic checkOp(input string name, input ctrlPkg::aluOp_t expected,
                           input ctrlPkg::aluOp_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            lineErrors++;
            $display("FAIL %0t %s expected %b actual %b", $time, name, expected, actual);
        end
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            lineErrors++;
            $display("FAIL %0t %s expected %b actual %b", $time, name, expected, actual);
        end
    endtask

    task automatic checkLink(input string name, input ctrlPkg::linkSel_t expected,
                             input ctrlPkg::linkSel_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            lineErrors++;
            $display("FAIL %0t %s expected %0d actual %0d", $time, name, expected, actual);
        end
    endtask

    // Execute levels of a valid instruction, from the decoder opcode map
    task automatic expectLevels(input isaPkg::opcode_t op, output logic pcSel,
                                output logic regJmp, output logic bFlag,
                                output ctrlPkg::linkSel_t link, output logic val2Reg,
                                output logic aluSel);
        logic rFormat;
        logic branch;
        logic jump;

        rFormat = (op == 5'b11001) || (op[4:1] == 4'b1101) || (op[4:2] == 3'b111);
        branch  = (op[4:2] == 3'b011);               // BEQZ to BGEZ
        jump    = (op[4:2] == 3'b001);               // J, JR, JAL, JALR
        pcSel   = jump && !op[0];                    // J and JAL
        regJmp  = jump && op[0];                     // JR and JALR
        bFlag   = (op[4:2] == 3'b000) || branch || (jump && op != 5'b00111);
        val2Reg = (op == 5'b10001);                  // LD only
        aluSel  = !(rFormat || branch);              // Immediate as second operand
        if (op == 5'b11000)
            link = ctrlPkg::linkLbi;
        else if (jump && op[1])
            link = ctrlPkg::linkJump;                // JAL and JALR
        else
            link = ctrlPkg::linkNone;
    endtask

    initial begin
        int                fd;
        int                code;
        int                lineNo;
        int                tests;
        logic              done;
        logic              aborted;
        logic [8*256-1:0]  headerLine;
        isaPkg::word_t     vInstr;
        logic              vValid;
        logic              vStall;
        logic              vFlush;
        logic              vWbEnable;
        isaPkg::regIdx_t   vWbReg;
        isaPkg::word_t     vWbData;
        logic              vCheck;
        logic              eValid;
        isaPkg::regIdx_t   eDest;
        ctrlPkg::aluOp_t   eOp;
        isaPkg::word_t     eImm;
        isaPkg::word_t     eRs;
        logic              eRegWrite;
        logic              eMemEnable;
        logic              eMemWr;
        logic              eHalted;
        logic              eSiic;
        logic              ePcSel;
        logic              eRegJmp;
        logic              eBFlag;
        ctrlPkg::linkSel_t eLink;
        logic              eVal2Reg;
        logic              eAluSel;
        isaPkg::word_t     latchModel;                  // Instruction the latch should hold
        isaPkg::word_t     exModel;                     // Instruction in the execute register
        isaPkg::word_t     rtModel;                     // Rt operand read along with it
        isaPkg::word_t     shadowRegs [`REG_COUNT];     // Register contents seen by reads

        reset      = 1'b1;
        instr      = '0;
        instrValid = 1'b0;
        stall      = 1'b0;
        flush      = 1'b0;
        wbEnable   = 1'b0;
        wbReg      = '0;
        wbData     = '0;
        lineNo     = 0;
        tests      = 0;
        done       = 1'b0;
        aborted    = 1'b0;
        latchModel = '0;
        exModel    = '0;
        rtModel    = '0;
        for (int r = 0; r < `REG_COUNT; r++)
            shadowRegs[r] = '0;

        repeat (2) @(posedge clk);
        reset <= 1'b0;

        fd = $fopen("tb/decode_vectors.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open tb/decode_vectors.txt");
            aborted = 1'b1;
            done    = 1'b1;
        end else begin
            code = $fgets(headerLine, fd);  // Two column description lines
            code = $fgets(headerLine, fd);
        end

        while (!done) begin
            if (lineNo >= maxLines) begin
                $display("ERROR: timeout, vector file exceeds %0d lines", maxLines);
                aborted = 1'b1;
                done    = 1'b1;
            end else begin
                code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h\n",
                               vInstr, vValid, vStall, vFlush, vWbEnable, vWbReg, vWbData,
                               vCheck, eValid, eDest, eOp, eImm, eRs, eRegWrite,
                               eMemEnable, eMemWr, eHalted, eSiic);
                if (code != 18) begin
                    if (code != -1) begin
                        $display("ERROR: vector %0d is malformed", lineNo);
                        aborted = 1'b1;
                    end
                    done = 1'b1;
                end else begin
                    @(posedge clk);
                    instr      <= vInstr;
                    instrValid <= vValid;
                    stall      <= vStall;
                    flush      <= vFlush;
                    wbEnable   <= vWbEnable;
                    wbReg      <= vWbReg;
                    wbData     <= vWbData;
                    @(negedge clk);              // Outputs settled after the edge
                    if (vCheck) begin
                        lineErrors = 0;
                        tests++;
                        ePcSel  = 1'b0;          // Bubble and reset levels
                        eRegJmp = 1'b0;
                        eBFlag  = 1'b0;
                        eLink   = ctrlPkg::linkNone;
                        checkBit("exValid", eValid, exValid);
                        checkBit("exRegWrite", eRegWrite, exRegWrite);
                        checkBit("exMemEnable", eMemEnable, exMemEnable);
                        checkBit("exMemWr", eMemWr, exMemWr);
                        checkBit("exSiic", eSiic, exSiic);
                        checkBit("halted", eHalted, halted);
                        if (eValid) begin        // Data only means something when valid
                            expectLevels(exModel[`WORD_WIDTH-1 -: 5], ePcSel, eRegJmp,
                                         eBFlag, eLink, eVal2Reg, eAluSel);
                            checkReg("exDestReg", eDest, exDestReg);
                            checkOp("exAluOp", eOp, exAluOp);
                            checkWord("exImm", eImm, exImm);
                            checkWord("exRsData", eRs, exRsData);
                            checkWord("exRtData", rtModel, exRtData);
                            checkBit("exVal2Reg", eVal2Reg, exVal2Reg);
                            checkBit("exAluSel", eAluSel, exAluSel);
                        end
                        checkBit("exPcSel", ePcSel, exPcSel);
                        checkBit("exRegJmp", eRegJmp, exRegJmp);
                        checkBit("exBFlag", eBFlag, exBFlag);
                        checkLink("exLinkSel", eLink, exLinkSel);
                        $display("test %0d vector %0d: %s", tests, lineNo,
                                 lineErrors == 0 ? "ok" : "mismatch");
                    end
                    if (vWbEnable)
                        shadowRegs[vWbReg] = vWbData;  // Bypass shows it to this read
                    if (!vStall) begin
                        rtModel = shadowRegs[latchModel[7:5]];
                        exModel = latchModel;
                        if (vValid && !vFlush)
                            latchModel = vInstr;     // Stalled or flushed strobes are lost
                    end
                    lineNo++;
                end
            end
        end

        if (fd != 0)
            $fclose(fd);
        if (!aborted && tests == 0) begin
            $display("ERROR: no checked vectors were read");
            aborted = 1'b1;
        end
        $display("Summary: %0d tests, %0d checks, %0d mismatches, %0d assertion failures",
                 tests, checks, errors, dut.chk.failCount);
        if (errors == 0 && !aborted && dut.chk.failCount == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/decode_vectors.txt
# instr valid stall flush wbEn wbReg wbData | chk exValid exDest exAluOp exImm exRsData
# exRegWrite exMemEnable exMemWr halted exSiic (all hex, one line per clock)
0000 0 0 0 1 1 1234 1 0 0 00 0000 0000 0 0 0 0 0
0000 0 0 0 1 2 00ff 0 0 0 00 0000 0000 0 0 0 0 0
0000 0 0 0 1 3 beef 0 0 0 00 0000 0000 0 0 0 0 0
d950 1 0 0 0 0 0000 1 0 0 00 0000 0000 0 0 0 0 0
42b1 1 0 0 0 0 0000 1 0 0 00 0000 0000 0 0 0 0 0
8326 1 0 0 0 0 0000 1 1 4 1b 0010 1234 1 0 0 0 0
89df 1 0 0 0 0 0000 1 1 5 08 fff1 00ff 1 0 0 0 0
9a6f 1 0 0 0 0 0000 1 1 1 10 0006 beef 0 1 1 0 0
dc3c 1 0 0 0 0 0000 1 1 6 11 ffff 1234 1 1 0 0 0
33ff 1 0 0 1 4 4444 1 1 2 13 000f 00ff 1 1 1 0 0
2401 1 0 0 0 0 0000 1 1 7 1b 001c 4444 1 0 0 0 0
2980 1 0 0 0 0 0000 1 1 7 08 03ff beef 1 0 0 0 0
5955 1 0 0 0 0 0000 1 1 7 08 fc01 4444 0 0 0 0 0
93a5 1 0 0 0 0 0000 1 1 7 08 ff80 1234 0 0 0 0 0
c59c 1 0 0 0 0 0000 1 1 2 0b 0015 1234 1 0 0 0 0
627f 1 0 0 0 0 0000 1 1 3 12 00a5 beef 1 0 0 0 0
0800 1 0 0 0 0 0000 1 1 5 18 ff9c 0000 1 0 0 0 0
1800 1 0 0 0 0 0000 1 1 2 0c 007f 00ff 0 0 0 0 0
1000 1 0 0 0 0 0000 1 1 0 01 0000 0000 0 0 0 0 0
496a 1 0 0 0 0 0000 1 1 0 01 0000 0000 0 0 0 0 0
496a 0 1 0 0 0 0000 1 1 0 02 0000 0000 0 0 0 0 1
8326 1 1 0 0 0 0000 1 0 0 00 0000 0000 0 0 0 0 0
0000 0 0 0 0 0 0000 1 0 0 00 0000 0000 0 0 0 0 0
5238 1 0 0 0 0 0000 1 1 3 09 000a 1234 1 0 0 0 0
0000 0 1 0 0 0 0000 1 0 0 00 0000 0000 0 0 0 0 0
0000 0 1 1 0 0 0000 1 0 0 00 0000 0000 0 0 0 0 0
0000 0 0 0 0 0 0000 1 0 0 00 0000 0000 0 0 0 0 0
0000 0 0 0 0 0 0000 1 0 0 00 0000 0000 0 0 0 0 0
42b1 1 0 1 0 0 0000 1 0 0 00 0000 0000 0 0 0 0 0
0000 1 0 0 0 0 0000 1 0 0 00 0000 0000 0 0 0 0 0
d950 1 0 0 0 0 0000 1 0 0 00 0000 0000 0 0 0 0 0
42b1 1 0 0 0 0 0000 1 1 0 00 0000 0000 0 0 0 0 0
8326 1 0 0 0 0 0000 1 0 0 00 0000 0000 0 0 0 1 0
0000 0 0 0 0 0 0000 1 0 0 00 0000 0000 0 0 0 1 0
0000 0 0 0 0 0 0000 1 0 0 00 0000 0000 0 0 0 1 0

//--- sources.f
+incdir+hdl
hdl/isa_pkg.sv
hdl/ctrl_pkg.sv
hdl/instrLatch.sv
hdl/control.sv
hdl/immExtend.sv
hdl/regFile.sv
hdl/decodeOut.sv
hdl/decodeStage.sv
tb/decodeStage_chk.sv
tb/decodeStage_tb.sv
